// File: common/gba_io_settings.svh
/*
 * I/O subsystem settings
 * Frame geometry, line divider width and timer count
 */
`ifndef GBA_IO_SETTINGS_SVH
`define GBA_IO_SETTINGS_SVH

// Scanlines per frame, last one is GBA_LINES-1
`define GBA_LINES 228

// Line at which vblank starts
`define GBA_VBLANK_LINE 160

// Cycles per line are 2**GBA_LINE_DIV_BITS, kept small for simulation
`define GBA_LINE_DIV_BITS 4

`define GBA_NUM_TIMERS 4

`endif

// File: common/gba_io_pkg.sv
/*
 * I/O map package
 * Register indices and timer prescale choices
 */
`default_nettype none

package gba_io_pkg;

    typedef enum logic [4:0] {
        DISPSTAT = 5'd0,
        VCOUNT   = 5'd1,
        TM0CNT_L = 5'd2,
        TM1CNT_L = 5'd3,
        TM2CNT_L = 5'd4,
        TM3CNT_L = 5'd5,
        TM0CNT_H = 5'd6,
        TM1CNT_H = 5'd7,
        TM2CNT_H = 5'd8,
        TM3CNT_H = 5'd9,
        IE       = 5'd10,
        IF       = 5'd11,
        IME      = 5'd12,
        LED_REG0 = 5'd13,
        LED_REG1 = 5'd14,
        LED_REG2 = 5'd15,
        LED_REG3 = 5'd16
    } io_reg_e;

    // TMxCNT_H bits 1:0
    typedef enum logic [1:0] {
        DIV1    = 2'd0,
        DIV64   = 2'd1,
        DIV256  = 2'd2,
        DIV1024 = 2'd3
    } tm_prescale_e;

endpackage

`default_nettype wire

// File: common/gba_irq_pkg.sv
/*
 * Interrupt package
 * IE and IF bit positions, processor modes
 */
`default_nettype none

package gba_irq_pkg;

    typedef enum logic [3:0] {
        IRQ_VBLANK = 4'd0,
        IRQ_VCOUNT = 4'd2,
        IRQ_TIMER0 = 4'd3,
        IRQ_TIMER1 = 4'd4,
        IRQ_TIMER2 = 4'd5,
        IRQ_TIMER3 = 4'd6
    } irq_src_e;

    // CPSR mode field encodings
    typedef enum logic [4:0] {
        USR = 5'b10000,
        FIQ = 5'b10001,
        IRQ = 5'b10010,
        SVC = 5'b10011,
        ABT = 5'b10111,
        UND = 5'b11011,
        SYS = 5'b11111
    } cpu_mode_e;

endpackage

`default_nettype wire

// File: common/io_bus_if.sv
/*
 * I/O register bus
 * Single-cycle write strobe with combinational read data
 */
`timescale 1ns/1ps
`default_nettype none

interface io_bus_if;

    logic                 we;
    gba_io_pkg::io_reg_e  idx;
    logic [15:0]          wdata;
    logic [15:0]          rdata;

    modport host (
        output we, idx, wdata,
        input  rdata
    );

    modport regs (
        input  we, idx, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: hw/video_count.sv
/*
 * Scanline counter
 * Divides the clock into lines, counts lines per frame and
 * pulses vblank and vcount-match as the line changes
 */
`timescale 1ns/1ps
`default_nettype none
`include "gba_io_settings.svh"

module video_count (
    input  logic       gba_clk,
    input  logic       BTND,
    input  logic [7:0] vcount_cmp,
    output logic [7:0] vcount,
    output logic       vblank,
    output logic       vcount_match
);

    logic [`GBA_LINE_DIV_BITS-1:0] div;
    logic                          line_end;
    logic [7:0]                    next_line;

    assign line_end  = &div;
    assign next_line = (vcount == 8'(`GBA_LINES - 1)) ? 8'd0 : vcount + 8'd1;

    always_ff @(posedge gba_clk, posedge BTND) begin
        if (BTND) begin
            div          <= '0;
            vcount       <= '0;
            vblank       <= 1'b0;
            vcount_match <= 1'b0;
        end else begin
            div <= div + 1'b1;
            // Pulses line up with the new vcount value
            vblank       <= line_end && (next_line == 8'(`GBA_VBLANK_LINE));
            vcount_match <= line_end && (next_line == vcount_cmp);
            if (line_end) begin
                vcount <= next_line;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/timers/timer_bank.sv
/*
 * Timer bank
 * Four 16-bit up counters with reload, shared prescaler,
 * cascade from the previous timer and overflow interrupt pulses
 */
`timescale 1ns/1ps
`default_nettype none
`include "gba_io_settings.svh"

module timer_bank (
    input  logic                       gba_clk,
    input  logic                       BTND,
    input  logic [15:0]                reload [`GBA_NUM_TIMERS],
    input  logic [15:0]                ctrl [`GBA_NUM_TIMERS],
    output logic [15:0]                count [`GBA_NUM_TIMERS],
    output logic [`GBA_NUM_TIMERS-1:0] overflow
);

    import gba_io_pkg::*;

    logic [9:0]                 presc;
    logic [`GBA_NUM_TIMERS-1:0] en_q;
    logic [`GBA_NUM_TIMERS-1:0] step;
    logic [`GBA_NUM_TIMERS-1:0] ovf;

    // ctrl bits: 1:0 prescale, 2 cascade, 6 irq enable, 7 enable
    always_comb begin
        logic pre_tick;
        logic carry;
        carry = 1'b0;
        for (int i = 0; i < `GBA_NUM_TIMERS; i++) begin
            case (tm_prescale_e'(ctrl[i][1:0]))
                DIV1:    pre_tick = 1'b1;
                DIV64:   pre_tick = &presc[5:0];
                DIV256:  pre_tick = &presc[7:0];
                DIV1024: pre_tick = &presc;
                default: pre_tick = 1'b0;
            endcase
            // Timer 0 has no predecessor to cascade from
            if (i > 0 && ctrl[i][2]) begin
                step[i] = carry;
            end else begin
                step[i] = pre_tick;
            end
            step[i] = step[i] && ctrl[i][7] && en_q[i];
            ovf[i]  = step[i] && (count[i] == 16'hFFFF);
            carry   = ovf[i];
        end
    end

    always_ff @(posedge gba_clk, posedge BTND) begin
        if (BTND) begin
            presc    <= '0;
            en_q     <= '0;
            overflow <= '0;
            for (int i = 0; i < `GBA_NUM_TIMERS; i++) begin
                count[i] <= '0;
            end
        end else begin
            presc <= presc + 10'd1;
            for (int i = 0; i < `GBA_NUM_TIMERS; i++) begin
                en_q[i]     <= ctrl[i][7];
                overflow[i] <= ovf[i] && ctrl[i][6];
                // Load on enable rise and on wrap
                if ((ctrl[i][7] && !en_q[i]) || ovf[i]) begin
                    count[i] <= reload[i];
                end else if (step[i]) begin
                    count[i] <= count[i] + 16'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/io_regs.sv
/*
 * I/O register file
 * Holds DISPSTAT compare, timer, IE, IF, IME and LED registers,
 * captures event pulses into IF and drives the registered IRQ line
 */
`timescale 1ns/1ps
`default_nettype none
`include "gba_io_settings.svh"

module io_regs (
    input  logic                    gba_clk,
    input  logic                    BTND,
    io_bus_if.regs                  bus,
    input  gba_irq_pkg::cpu_mode_e  cpu_mode,
    input  logic [7:0]              vcount,
    input  logic                    vblank,
    input  logic                    vcount_match,
    input  logic [15:0]             tm_count [`GBA_NUM_TIMERS],
    input  logic [`GBA_NUM_TIMERS-1:0] tm_overflow,
    output logic [15:0]             tm_reload [`GBA_NUM_TIMERS],
    output logic [15:0]             tm_ctrl [`GBA_NUM_TIMERS],
    output logic [7:0]              vcount_cmp,
    output logic [15:0]             led_regs [4],
    output logic                    n_irq
);

    import gba_io_pkg::*;
    import gba_irq_pkg::*;

    logic [15:0] ie;
    logic [15:0] if_reg;
    logic        ime;
    logic [15:0] events;
    logic [15:0] if_ack;
    logic [1:0]  tm_sel;
    logic [1:0]  led_sel;
    logic        in_vblank;

    // Slot within the TMxCNT_L, TMxCNT_H and LED_REGx groups
    assign tm_sel  = (bus.idx >= TM0CNT_H) ? 2'(bus.idx - TM0CNT_H) : 2'(bus.idx - TM0CNT_L);
    assign led_sel = 2'(bus.idx - LED_REG0);

    assign in_vblank = (vcount >= 8'(`GBA_VBLANK_LINE));

    always_comb begin
        events = '0;
        events[IRQ_VBLANK] = vblank;
        events[IRQ_VCOUNT] = vcount_match;
        events[IRQ_TIMER0 +: `GBA_NUM_TIMERS] = tm_overflow;
        if_ack = (bus.we && bus.idx == IF) ? bus.wdata : 16'h0000;
    end

    always_ff @(posedge gba_clk, posedge BTND) begin
        if (BTND) begin
            vcount_cmp <= '0;
            ie         <= '0;
            if_reg     <= '0;
            ime        <= 1'b0;
            n_irq      <= 1'b1;
            for (int i = 0; i < `GBA_NUM_TIMERS; i++) begin
                tm_reload[i] <= '0;
                tm_ctrl[i]   <= '0;
            end
            for (int i = 0; i < 4; i++) begin
                led_regs[i] <= '0;
            end
        end else begin
            if (bus.we) begin
                case (bus.idx)
                    DISPSTAT: vcount_cmp <= bus.wdata[15:8];
                    TM0CNT_L, TM1CNT_L, TM2CNT_L, TM3CNT_L: tm_reload[tm_sel] <= bus.wdata;
                    TM0CNT_H, TM1CNT_H, TM2CNT_H, TM3CNT_H: tm_ctrl[tm_sel] <= bus.wdata;
                    IE:       ie <= bus.wdata;
                    IME:      ime <= bus.wdata[0];
                    LED_REG0, LED_REG1, LED_REG2, LED_REG3: led_regs[led_sel] <= bus.wdata;
                    default: ;
                endcase
            end
            // New events win over an acknowledge in the same cycle
            if_reg <= (if_reg & ~if_ack) | events;
            n_irq  <= !(ime && |(ie & if_reg) && cpu_mode != IRQ);
        end
    end

    always_comb begin
        case (bus.idx)
            DISPSTAT: bus.rdata = {vcount_cmp, 5'h00, vcount == vcount_cmp, 1'b0, in_vblank};
            VCOUNT:   bus.rdata = {8'h00, vcount};
            TM0CNT_L, TM1CNT_L, TM2CNT_L, TM3CNT_L: bus.rdata = tm_count[tm_sel];
            TM0CNT_H, TM1CNT_H, TM2CNT_H, TM3CNT_H: bus.rdata = tm_ctrl[tm_sel];
            IE:       bus.rdata = ie;
            IF:       bus.rdata = if_reg;
            IME:      bus.rdata = {15'h0000, ime};
            LED_REG0, LED_REG1, LED_REG2, LED_REG3: bus.rdata = led_regs[led_sel];
            default:  bus.rdata = 16'h0000;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/led_debug.sv
/*
 * LED debug mux
 * Shows a byte of the LED registers or the buttons on the board LEDs
 */
`timescale 1ns/1ps
`default_nettype none

module led_debug (
    input  logic [15:0] led_regs [4],
    input  logic [15:0] buttons,
    input  logic [7:0]  sw,
    output logic [7:0]  ld
);

    always_comb begin
        if (sw < 8'd8) begin
            // Register sw/2, odd values pick the high byte
            if (sw[0]) begin
                ld = led_regs[sw[2:1]][15:8];
            end else begin
                ld = led_regs[sw[2:1]][7:0];
            end
        end else if (sw[7]) begin
            ld = buttons[15:8];
        end else begin
            ld = buttons[7:0];
        end
    end

endmodule

`default_nettype wire

// File: hw/gba_io_top.sv
/*
 * I/O and interrupt subsystem top
 * Event sources feed the register file, which raises n_irq
 */
`timescale 1ns/1ps
`default_nettype none
`include "gba_io_settings.svh"

module gba_io_top (
    input  logic                    gba_clk,
    input  logic                    BTND,
    input  logic                    bus_we,
    input  gba_io_pkg::io_reg_e     bus_idx,
    input  logic [15:0]             bus_wdata,
    output logic [15:0]             bus_rdata,
    input  gba_irq_pkg::cpu_mode_e  cpu_mode,
    input  logic [15:0]             buttons,
    input  logic [7:0]              sw,
    output logic [7:0]              ld,
    output logic [7:0]              vcount,
    output logic                    n_irq
);

    io_bus_if bus ();

    logic [15:0]                tm_reload [`GBA_NUM_TIMERS];
    logic [15:0]                tm_ctrl [`GBA_NUM_TIMERS];
    logic [15:0]                tm_count [`GBA_NUM_TIMERS];
    logic [`GBA_NUM_TIMERS-1:0] tm_overflow;
    logic [7:0]                 vcount_cmp;
    logic                       vblank;
    logic                       vcount_match;
    logic [15:0]                led_regs [4];

    assign bus.we    = bus_we;
    assign bus.idx   = bus_idx;
    assign bus.wdata = bus_wdata;
    assign bus_rdata = bus.rdata;

    video_count u_video_count (
        .gba_clk, .BTND, .vcount_cmp, .vcount, .vblank, .vcount_match
    );

    timer_bank u_timer_bank (
        .gba_clk, .BTND,
        .reload(tm_reload), .ctrl(tm_ctrl),
        .count(tm_count), .overflow(tm_overflow)
    );

    io_regs u_io_regs (
        .gba_clk, .BTND, .bus(bus.regs), .cpu_mode,
        .vcount, .vblank, .vcount_match,
        .tm_count, .tm_overflow, .tm_reload, .tm_ctrl,
        .vcount_cmp, .led_regs, .n_irq
    );

    led_debug u_led_debug (
        .led_regs, .buttons, .sw, .ld
    );

endmodule

`default_nettype wire

// File: testbench/gba_io_assertions.sv
/*
 * Interrupt and event assertions
 * Bound into the register file, where the event pulses arrive
 */
`timescale 1ns/1ps
`default_nettype none
`include "gba_io_settings.svh"

module gba_io_assertions (
    input logic                       gba_clk,
    input logic                       BTND,
    input logic                       n_irq,
    input logic                       vblank,
    input logic                       vcount_match,
    input logic [`GBA_NUM_TIMERS-1:0] tm_overflow
);

    int assert_fails = 0;

    n_irq_in_reset: assert property (@(posedge gba_clk) BTND |-> n_irq)
        else begin
            assert_fails++;
            $error("n_irq low while reset is held");
        end

    vblank_one_cycle: assert property (@(posedge gba_clk) disable iff (BTND) vblank |=> !vblank)
        else begin
            assert_fails++;
            $error("vblank pulse longer than one cycle");
        end

    // Sources are cleared by reset
    no_event_in_reset: assert property (@(posedge gba_clk)
        BTND |-> !(vblank || vcount_match || |tm_overflow))
        else begin
            assert_fails++;
            $error("event pulse while reset is held");
        end

endmodule

bind io_regs gba_io_assertions u_io_assertions (
    .gba_clk(gba_clk), .BTND(BTND), .n_irq(n_irq),
    .vblank(vblank), .vcount_match(vcount_match), .tm_overflow(tm_overflow)
);

`default_nettype wire

// File: testbench/gba_io_tb.sv
/*
 * Testbench for the I/O and interrupt subsystem
 * Runs register, LED, timer, interrupt and scanline steps from a data file
 */
`timescale 1ns/1ps
`default_nettype none
`include "gba_io_settings.svh"

module gba_io_tb;

    import gba_io_pkg::*;
    import gba_irq_pkg::*;

    logic        gba_clk;
    logic        BTND;
    logic        bus_we;
    io_reg_e     bus_idx;
    logic [15:0] bus_wdata;
    logic [15:0] bus_rdata;
    cpu_mode_e   cpu_mode;
    logic [15:0] buttons;
    logic [7:0]  sw;
    logic [7:0]  ld;
    logic [7:0]  vcount;
    logic        n_irq;

    string       step_op[$];
    logic [15:0] step_idx[$];
    logic [15:0] step_data[$];
    logic [15:0] step_exp[$];
    string       step_name[$];

    int pass_count = 0;
    int fail_count = 0;
    int cycles = 0;
    int limit = 0;

    gba_io_top gba_io_top_inst (
        .gba_clk(gba_clk), .BTND(BTND),
        .bus_we(bus_we), .bus_idx(bus_idx), .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
        .cpu_mode(cpu_mode), .buttons(buttons), .sw(sw), .ld(ld),
        .vcount(vcount), .n_irq(n_irq)
    );

    initial begin
        gba_clk = 1'b0;
        forever #20 gba_clk = ~gba_clk;
    end

    task automatic compare_data(input string name, input logic [15:0] exp_v,
                                input logic [15:0] act);
        if (act !== exp_v) begin
            $display("MISMATCH %s expected %h actual %h", name, exp_v, act);
            fail_count++;
        end else begin
            $display("ok %s %h", name, act);
            pass_count++;
        end
    endtask

    task automatic compare_irq(input string name, input logic exp_v, input logic act);
        if (act !== exp_v) begin
            $display("MISMATCH %s expected %b actual %b", name, exp_v, act);
            fail_count++;
        end else begin
            $display("ok %s %b", name, act);
            pass_count++;
        end
    endtask

    task automatic compare_led(input string name, input logic [7:0] exp_v,
                               input logic [7:0] act);
        if (act !== exp_v) begin
            $display("MISMATCH %s expected %h actual %h", name, exp_v, act);
            fail_count++;
        end else begin
            $display("ok %s %h", name, act);
            pass_count++;
        end
    endtask

    // Lines that do not hold five fields are comments
    task automatic load_steps();
        int          fd;
        int          n;
        string       line;
        string       op;
        string       name;
        logic [15:0] idx_v;
        logic [15:0] data_v;
        logic [15:0] exp_v;
        fd = $fopen("testbench/gba_io_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file testbench/gba_io_input.txt");
            fail_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %h %h %h %s", op, idx_v, data_v, exp_v, name);
                if (n == 5) begin
                    step_op.push_back(op);
                    step_idx.push_back(idx_v);
                    step_data.push_back(data_v);
                    step_exp.push_back(exp_v);
                    step_name.push_back(name);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_step(input string op, input logic [15:0] idx_v,
                            input logic [15:0] data_v, input logic [15:0] exp_v,
                            input string name);
        case (op)
            "W": begin
                @(posedge gba_clk);
                bus_we    <= 1'b1;
                bus_idx   <= io_reg_e'(idx_v[4:0]);
                bus_wdata <= data_v;
                @(posedge gba_clk);
                bus_we <= 1'b0;
                $display("wrote %s %h", name, data_v);
            end
            "R", "P": begin
                @(posedge gba_clk);
                bus_idx <= io_reg_e'(idx_v[4:0]);
                @(negedge gba_clk);
                // Polls stop only on a match or at the timeout
                while (op == "P" && (bus_rdata & data_v) !== exp_v) begin
                    @(negedge gba_clk);
                end
                compare_data(name, exp_v, bus_rdata & data_v);
                // The vcount port shows the same line as the VCOUNT register
                if (io_reg_e'(idx_v[4:0]) == VCOUNT) begin
                    compare_data({name, "_port"}, exp_v, {8'h00, vcount} & data_v);
                end
            end
            "C": begin
                @(posedge gba_clk);
                bus_idx <= io_reg_e'(idx_v[4:0]);
                @(negedge gba_clk);
                if (bus_rdata < 16'(`GBA_LINES)) begin
                    $display("ok %s %h", name, bus_rdata);
                    pass_count++;
                end else begin
                    $display("%s: line %0d is not below the line count", name, bus_rdata);
                    fail_count++;
                end
            end
            "I": begin
                // n_irq follows its inputs one edge later
                @(posedge gba_clk);
                @(posedge gba_clk);
                @(negedge gba_clk);
                compare_irq(name, exp_v[0], n_irq);
            end
            "M": begin
                @(posedge gba_clk);
                cpu_mode <= cpu_mode_e'(data_v[4:0]);
                $display("set %s %h", name, data_v[4:0]);
            end
            "B": begin
                @(posedge gba_clk);
                buttons <= data_v;
                $display("set %s %h", name, data_v);
            end
            "L": begin
                @(posedge gba_clk);
                sw <= data_v[7:0];
                @(negedge gba_clk);
                compare_led(name, exp_v[7:0], ld);
            end
            default: begin
                $display("%s: unknown operation %s in the stimulus file", name, op);
                fail_count++;
            end
        endcase
    endtask

    initial begin
        BTND      = 1'b1;
        bus_we    = 1'b0;
        bus_idx   = DISPSTAT;
        bus_wdata = 16'h0000;
        cpu_mode  = USR;
        buttons   = 16'h0000;
        sw        = 8'h00;
        load_steps();
        limit = 4 * `GBA_LINES * (1 << `GBA_LINE_DIV_BITS) + 200 * step_op.size();
        repeat (4) @(posedge gba_clk);
        BTND <= 1'b0;
        for (int i = 0; i < step_op.size(); i++) begin
            run_step(step_op[i], step_idx[i], step_data[i], step_exp[i], step_name[i]);
        end
        $display("%0d steps, %0d checks passed, %0d failed, %0d assertion failures",
                 step_op.size(), pass_count, fail_count,
                 gba_io_top_inst.u_io_regs.u_io_assertions.assert_fails);
        if (fail_count == 0 &&
            gba_io_top_inst.u_io_regs.u_io_assertions.assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge gba_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a step never completed", limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/gba_io_input.txt
# op idx data expected name, hex; W write, R read with data as mask, P poll until masked read
# matches, C vcount below line count, I n_irq, M cpu mode, B buttons, L sw=data gives ld
R 0a ffff 0000 ie_reset
R 0b ffff 0000 if_reset
R 0c ffff 0000 ime_reset
R 0d ffff 0000 led0_reset
I 00 0000 0001 irq_reset
W 0a 0008 0000 ie_write
R 0a ffff 0008 ie_read
W 0c 0001 0000 ime_write
R 0c ffff 0001 ime_read
W 0d 1234 0000 led0_write
W 0e 5678 0000 led1_write
W 0f 9abc 0000 led2_write
W 10 def0 0000 led3_write
R 0e ffff 5678 led1_read
R 10 ffff def0 led3_read
B 00 a55a 0000 buttons
L 00 0000 0034 led_sw0
L 00 0001 0012 led_sw1
L 00 0002 0078 led_sw2
L 00 0003 0056 led_sw3
L 00 0004 00bc led_sw4
L 00 0005 009a led_sw5
L 00 0006 00f0 led_sw6
L 00 0007 00de led_sw7
L 00 0008 005a led_sw08
L 00 0080 00a5 led_sw80
L 00 00ff 00a5 led_swff
M 00 0012 0000 mode_irq
W 03 0000 0000 tm1_reload
W 07 0084 0000 tm1_cascade
W 02 fff0 0000 tm0_reload
W 06 00c0 0000 tm0_start
P 0b 0008 0008 if_timer0
I 00 0000 0001 irq_mode_irq
M 00 0010 0000 mode_usr
I 00 0000 0000 irq_low
P 03 ffff 0001 tm1_count1
P 03 ffff 0002 tm1_count2
P 03 ffff 0003 tm1_count3
R 0b 0010 0000 if_timer1_off
W 06 0000 0000 tm0_stop
W 0b 0008 0000 if_ack
I 00 0000 0001 irq_release
R 0b 0008 0000 if_timer0_clear
W 00 2000 0000 vcount_cmp
P 01 00ff 00a1 vcount_161
R 0b 0005 0005 if_vblank_vcount
R 00 ff01 2001 dispstat_vblank
C 01 0000 0000 vcount_bound
I 00 0000 0001 irq_still_high

// File: src.f
+incdir+common
common/gba_io_pkg.sv
common/gba_irq_pkg.sv
common/io_bus_if.sv
hw/video_count.sv
hw/timers/timer_bank.sv
hw/io_regs.sv
hw/led_debug.sv
hw/gba_io_top.sv
testbench/gba_io_assertions.sv
testbench/gba_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module gba_io_tb -f src.f -o gba_io_sim
./obj_dir/gba_io_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
